// File: src/spu_pkg.sv
`default_nettype none

package spu_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------
	localparam int NUM_SPRITES = 32;
	localparam int SPR_NUM_W   = 5;	// sprite number
	localparam int VLINES      = 288;	// lines per frame
	localparam int LINE_W      = 512;	// line buffer depth
	localparam int X_W         = 9;	// line buffer address
	localparam int SMEM_AW     = 9;	// sprite memory word address
	localparam int SMEM_LAT    = 2;	// req to rdy, clocks
	localparam int OFFS_W      = 14;	// row offset, words
	localparam int PIX_PERIOD  = 4;	// clocks per output pixel

	// colour resolution, descriptor byte 4 bits 1..0
	typedef enum logic [1:0] {
		CRES_OFF = 2'd0,
		CRES_4C  = 2'd1,
		CRES_16C = 2'd2,
		CRES_TC  = 2'd3
	} cres_e;

	typedef enum logic [1:0] {
		HT_SFILE = 2'd0,
		HT_PAL   = 2'd1,
		HT_SMEM  = 2'd2
	} host_target_e;

	// sequencer states
	typedef enum logic [4:0] {
		IDLE      = 5'd0,
		BEGIN     = 5'd1,	// byte 4, cres and pal
		YPOS_LO   = 5'd2,
		YPOS_HI   = 5'd3,	// visibility test here
		XPOS_LO   = 5'd4,
		XPOS_HI   = 5'd5,
		ADR_LO    = 5'd6,
		ADR_HI    = 5'd7,	// first word request
		WAIT_DATA = 5'd8,
		PIX       = 5'd9,
		END_WORD  = 5'd10,
		HALT      = 5'd31
	} seq_state_e;

	// ----------------------------------------------------------------------
	// bundles
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic we;
		host_target_e target;
		logic [SMEM_AW-1:0] addr;
		logic [15:0] data;
	} host_wr_t;

	typedef struct packed {
		logic en;	// opaque
		logic [5:0] color;
	} pix_t;

	typedef struct packed {
		logic req;
		logic [SMEM_AW-1:0] addr;
	} smem_req_t;

	typedef struct packed {
		logic rdy;
		logic [15:0] data;
	} smem_rsp_t;

	typedef struct packed {
		logic we;
		logic [X_W-1:0] addr;
		pix_t pix;
	} lb_wr_t;

endpackage

`default_nettype wire

// File: src/sprite_regfile.sv
`timescale 1ns/1ps
`default_nettype none

// sprite descriptor file, 8 bytes per sprite
// address is {sprite number, byte index}
module sprite_regfile (
	input  wire logic clk,
	input  wire spu_pkg::host_wr_t host,
	input  wire logic [7:0] sf_addr,
	output logic [7:0] sf_data
);

	logic [7:0] desc [spu_pkg::NUM_SPRITES * 8];	// 256 bytes
	logic sf_we;

	// host strobe aimed at the descriptor file
	assign sf_we = host.we && (host.target == spu_pkg::HT_SFILE);

	always_ff @(posedge clk)
	begin
		if (sf_we)
			desc[host.addr[7:0]] <= host.data[7:0];	// low byte only
	end

	// async read, sequencer samples it on the next edge
	assign sf_data = desc[sf_addr];

endmodule

`default_nettype wire

// File: src/sprite_palette.sv
`timescale 1ns/1ps
`default_nettype none

// palette, 256 entries
// bit 7 transparent, bits 5..0 colour, bit 6 not kept
module sprite_palette (
	input  wire logic clk,
	input  wire spu_pkg::host_wr_t host,
	input  wire logic [7:0] pal_addr,
	output logic [7:0] pal_data
);

	logic [6:0] ent [256];	// {transp, colour}
	logic [6:0] rd_ent;

	always_ff @(posedge clk)
	begin
		if (host.we && (host.target == spu_pkg::HT_PAL))
			ent[host.addr[7:0]] <= {host.data[7], host.data[5:0]};
	end

	// combinational lookup during pixel decode
	assign rd_ent   = ent[pal_addr];
	assign pal_data = {rd_ent[6], 1'b0, rd_ent[5:0]};

endmodule

`default_nettype wire

// File: src/sprite_mem.sv
`timescale 1ns/1ps
`default_nettype none

// sprite pixel words, 512 x 16
// level handshake, rdy comes SMEM_LAT edges after req and holds while req
module sprite_mem (
	input  wire logic clk,
	input  wire logic line_start,
	input  wire spu_pkg::host_wr_t host,
	input  wire spu_pkg::smem_req_t req,
	output spu_pkg::smem_rsp_t rsp
);

	logic [15:0] words [1 << spu_pkg::SMEM_AW];
	logic [1:0] lat_cnt;	// edges seen with req high

	// host load, full word
	always_ff @(posedge clk)
	begin
		if (host.we && (host.target == spu_pkg::HT_SMEM))
			words[host.addr] <= host.data;
	end

	// ----------------------------------------------------------------------
	// read side
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			lat_cnt <= '0;
			rsp     <= '0;
		end
		else if (!req.req)
		begin
			lat_cnt <= '0;	// request gone, drop rdy
			rsp.rdy <= 1'b0;
		end
		else if (!rsp.rdy)
		begin
			if (lat_cnt == 2'(spu_pkg::SMEM_LAT - 1))
			begin
				rsp.rdy  <= 1'b1;
				rsp.data <= words[req.addr];	// addr stable while req
			end
			else
				lat_cnt <= lat_cnt + 2'd1;
		end
	end

endmodule

`default_nettype wire

// File: src/sprite_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// per-line sprite walker
// scans sprites 0..31, fetches words, decodes pixels into the line buffer
module sprite_sequencer (
	input  wire logic clk,
	input  wire logic line_start,
	input  wire logic [8:0] line_num,
	output logic [7:0] sf_addr,
	input  wire logic [7:0] sf_data,
	output logic [7:0] pal_addr,
	input  wire logic [7:0] pal_data,
	output spu_pkg::smem_req_t smem_req,
	input  wire spu_pkg::smem_rsp_t smem_rsp,
	output spu_pkg::lb_wr_t lb_wr,
	output logic busy
);

	spu_pkg::seq_state_e state;
	spu_pkg::seq_state_e next_spr;	// where the walker goes after a sprite
	logic [spu_pkg::SPR_NUM_W-1:0] num;	// current sprite
	spu_pkg::cres_e cres;
	logic [5:0] pal;
	logic [7:0] ypos_lo;
	logic [8:0] adr;	// word address of row 0
	logic [spu_pkg::X_W-1:0] xcur;	// line buffer write position
	logic [6:0] words_left;
	logic [spu_pkg::OFFS_W-1:0] offs;
	logic [spu_pkg::OFFS_W-1:0] row_offs [spu_pkg::NUM_SPRITES];
	logic [15:0] sdbuf;	// word being shifted out
	logic [2:0] pix_cnt;	// pixels left in word, minus one
	logic [2:0] pix_top;
	logic [2:0] byte_sel;
	logic [8:0] ypos_w;
	logic [9:0] yend;
	logic [8:0] adr_now;
	logic [spu_pkg::OFFS_W-1:0] fetch_sum;
	logic last_spr, vis, first_row, tc, opaque, issue, take;

	// ----------------------------------------------------------------------
	// descriptor addressing and tests
	// ----------------------------------------------------------------------
	always_comb
	begin
		case (state)
			spu_pkg::YPOS_LO: byte_sel = 3'd2;
			spu_pkg::YPOS_HI: byte_sel = 3'd3;
			spu_pkg::XPOS_LO: byte_sel = 3'd0;
			spu_pkg::XPOS_HI: byte_sel = 3'd1;
			spu_pkg::ADR_LO:  byte_sel = 3'd5;
			spu_pkg::ADR_HI:  byte_sel = 3'd6;
			default:          byte_sel = 3'd4;	// cres/pal
		endcase
	end

	assign sf_addr = {num, byte_sel};

	assign last_spr = (num == spu_pkg::SPR_NUM_W'(spu_pkg::NUM_SPRITES - 1));
	assign next_spr = last_spr ? spu_pkg::HALT : spu_pkg::BEGIN;

	// valid in YPOS_HI only, sf_data is byte 3 there
	assign ypos_w    = {sf_data[7], ypos_lo};
	assign yend      = {1'b0, ypos_w} + {3'b0, sf_data[6:0]};
	assign vis       = (line_num >= ypos_w) && ({1'b0, line_num} < yend);
	assign first_row = (line_num == ypos_w);

	// word fetch
	assign adr_now   = (state == spu_pkg::ADR_HI) ? {sf_data[0], adr[7:0]} : adr;
	assign fetch_sum = spu_pkg::OFFS_W'(adr_now) + offs;
	// first word from ADR_HI, next one prefetched on the first pixel
	assign issue = (state == spu_pkg::ADR_HI) ||
		((state == spu_pkg::PIX) && (pix_cnt == pix_top) && (words_left != 7'd1));
	assign take  = (state == spu_pkg::WAIT_DATA) && smem_rsp.rdy;

	always_comb
	begin
		case (cres)
			spu_pkg::CRES_4C:  pix_top = 3'd7;	// 8 px/word
			spu_pkg::CRES_16C: pix_top = 3'd3;	// 4 px/word
			default:           pix_top = 3'd1;	// true colour, 2 px/word
		endcase
	end

	// ----------------------------------------------------------------------
	// pixel decode
	// ----------------------------------------------------------------------
	assign tc = (cres == spu_pkg::CRES_TC);
	assign pal_addr = (cres == spu_pkg::CRES_16C) ? {pal[5:2], sdbuf[15:12]}
		: {pal, sdbuf[15:14]};
	assign opaque = tc ? !sdbuf[15] : !pal_data[7];

	always_comb
	begin
		lb_wr.we        = (state == spu_pkg::PIX) && opaque;	// transparent skipped
		lb_wr.addr      = xcur;
		lb_wr.pix.en    = 1'b1;
		lb_wr.pix.color = tc ? sdbuf[13:8] : pal_data[5:0];
	end

	assign busy = (state != spu_pkg::IDLE) && (state != spu_pkg::HALT);

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state      <= spu_pkg::IDLE;
			num        <= '0;
			smem_req   <= '0;
			words_left <= '0;
			pix_cnt    <= '0;
		end
		else
		begin
			if (issue)
				smem_req <= {1'b1, fetch_sum[spu_pkg::SMEM_AW-1:0]};
			else if (take)
				smem_req.req <= 1'b0;	// mem drops rdy next edge

			case (state)
				spu_pkg::IDLE:
				begin
					num   <= '0;
					state <= spu_pkg::BEGIN;
				end
				spu_pkg::BEGIN:
				begin
					if (sf_data[1:0] == spu_pkg::CRES_OFF)
					begin
						num   <= num + 1'b1;	// inactive, skip
						state <= next_spr;
					end
					else
						state <= spu_pkg::YPOS_LO;
				end
				spu_pkg::YPOS_LO: state <= spu_pkg::YPOS_HI;
				spu_pkg::YPOS_HI:
				begin
					if (!vis)
					begin
						num   <= num + 1'b1;
						state <= next_spr;
					end
					else
						state <= spu_pkg::XPOS_LO;
				end
				spu_pkg::XPOS_LO: state <= spu_pkg::XPOS_HI;
				spu_pkg::XPOS_HI:
				begin
					words_left <= sf_data[6:0];
					if (sf_data[6:0] == 7'd0)
					begin
						num   <= num + 1'b1;	// zero width
						state <= next_spr;
					end
					else
						state <= spu_pkg::ADR_LO;
				end
				spu_pkg::ADR_LO: state <= spu_pkg::ADR_HI;
				spu_pkg::ADR_HI: state <= spu_pkg::WAIT_DATA;
				spu_pkg::WAIT_DATA:
				begin
					if (smem_rsp.rdy)
					begin
						pix_cnt <= pix_top;
						state   <= spu_pkg::PIX;
					end
				end
				spu_pkg::PIX:
				begin
					if (pix_cnt == 3'd0)
						state <= spu_pkg::END_WORD;
					else
						pix_cnt <= pix_cnt - 3'd1;
				end
				spu_pkg::END_WORD:
				begin
					if (words_left == 7'd1)
					begin
						num   <= num + 1'b1;	// row done
						state <= next_spr;
					end
					else
					begin
						words_left <= words_left - 7'd1;
						state      <= spu_pkg::WAIT_DATA;
					end
				end
				spu_pkg::HALT: state <= spu_pkg::HALT;
				default:       state <= spu_pkg::HALT;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// datapath, descriptor fields and row offsets
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (issue)
			offs <= offs + 1'b1;
		case (state)
			spu_pkg::BEGIN:
			begin
				cres <= spu_pkg::cres_e'(sf_data[1:0]);
				pal  <= sf_data[7:2];
			end
			spu_pkg::YPOS_LO: ypos_lo <= sf_data;
			spu_pkg::YPOS_HI: offs <= first_row ? '0 : row_offs[num];	// row 0 restarts
			spu_pkg::XPOS_LO: xcur[7:0] <= sf_data;
			spu_pkg::XPOS_HI: xcur[8] <= sf_data[7];
			spu_pkg::ADR_LO:  adr[7:0] <= sf_data;
			spu_pkg::ADR_HI:  adr[8] <= sf_data[0];
			spu_pkg::WAIT_DATA:
			begin
				if (smem_rsp.rdy)
					sdbuf <= smem_rsp.data;
			end
			spu_pkg::PIX:
			begin
				xcur <= xcur + 1'b1;
				case (cres)	// msb field first
					spu_pkg::CRES_4C:  sdbuf <= {sdbuf[13:0], 2'b0};
					spu_pkg::CRES_16C: sdbuf <= {sdbuf[11:0], 4'b0};
					default:           sdbuf <= {sdbuf[7:0], 8'b0};
				endcase
			end
			spu_pkg::END_WORD:
			begin
				if (words_left == 7'd1)
					row_offs[num] <= offs;	// start of next row
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: src/line_store.sv
`timescale 1ns/1ps
`default_nettype none

// line counter, bank select and the two line buffers
// one bank takes sprite writes, the other is shown and cleared behind
module line_store (
	input  wire logic clk,
	input  wire logic line_start,
	input  wire logic pre_vline,
	input  wire spu_pkg::lb_wr_t lb_wr,
	output logic [8:0] line_num,
	output spu_pkg::pix_t pix
);

	logic new_line;	// set by line_start, cleared on edge 1
	logic bank;	// drawing bank
	logic [$clog2(spu_pkg::PIX_PERIOD)-1:0] phase;
	logic [spu_pkg::X_W-1:0] rd_addr;
	spu_pkg::pix_t lbuf [2][spu_pkg::LINE_W] = '{default: '0};	// power-up empty
	logic [1:0] wr_en;
	logic [spu_pkg::X_W-1:0] wr_addr [2];
	spu_pkg::pix_t wr_data [2];

	// ----------------------------------------------------------------------
	// line counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
			new_line <= 1'b1;
		else
			new_line <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (new_line && !line_start)
		begin
			if (pre_vline)
			begin
				line_num <= '0;	// first visible line
				bank     <= 1'b0;
			end
			else
			begin
				line_num <= (line_num == 9'(spu_pkg::VLINES - 1)) ? '0 : line_num + 9'd1;
				bank     <= ~bank;
			end
		end
	end

	// ----------------------------------------------------------------------
	// readout, capture / null / advance / idle
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			phase   <= $bits(phase)'(spu_pkg::PIX_PERIOD - 1);	// idle, capture 2nd edge
			rd_addr <= '0;
			pix     <= '0;
		end
		else
		begin
			phase <= (phase == $bits(phase)'(spu_pkg::PIX_PERIOD - 1)) ? '0 : phase + 1'b1;
			case (phase)
				0:       pix <= lbuf[~bank][rd_addr];
				2:       rd_addr <= rd_addr + 1'b1;
				default: ;	// 1 is the null write below
			endcase
		end
	end

	// per-bank write port
	always_comb
	begin
		for (int b = 0; b < 2; b++)
		begin
			if (b == bank)
			begin
				wr_en[b]   = lb_wr.we;	// opaque sprite pixel
				wr_addr[b] = lb_wr.addr;
				wr_data[b] = lb_wr.pix;
			end
			else
			begin
				wr_en[b]   = (phase == 1);	// clear behind the read
				wr_addr[b] = rd_addr;
				wr_data[b] = '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int b = 0; b < 2; b++)
		begin
			if (wr_en[b])
				lbuf[b][wr_addr[b]] <= wr_data[b];
		end
	end

endmodule

`default_nettype wire

// File: src/sprite_unit.sv
`timescale 1ns/1ps
`default_nettype none

// sprite unit top
module sprite_unit (
	input  wire logic clk,
	input  wire logic line_start,	// reset and line start
	input  wire logic pre_vline,
	input  wire spu_pkg::host_wr_t host,
	output spu_pkg::pix_t pix,
	output logic busy
);

	logic [7:0] sf_addr;
	logic [7:0] sf_data;
	logic [7:0] pal_addr;
	logic [7:0] pal_data;
	logic [8:0] line_num;
	spu_pkg::smem_req_t smem_req;
	spu_pkg::smem_rsp_t smem_rsp;
	spu_pkg::lb_wr_t lb_wr;

	// ----------------------------------------------------------------------
	// host-loaded tables
	// ----------------------------------------------------------------------
	sprite_regfile u_regfile (
		.clk     (clk),
		.host    (host),
		.sf_addr (sf_addr),
		.sf_data (sf_data)
	);

	sprite_palette u_palette (
		.clk      (clk),
		.host     (host),
		.pal_addr (pal_addr),
		.pal_data (pal_data)
	);

	sprite_mem u_mem (
		.clk        (clk),
		.line_start (line_start),
		.host       (host),
		.req        (smem_req),
		.rsp        (smem_rsp)
	);

	// ----------------------------------------------------------------------
	// drawing and display
	// ----------------------------------------------------------------------
	sprite_sequencer u_seq (
		.clk        (clk),
		.line_start (line_start),
		.line_num   (line_num),
		.sf_addr    (sf_addr),
		.sf_data    (sf_data),
		.pal_addr   (pal_addr),
		.pal_data   (pal_data),
		.smem_req   (smem_req),
		.smem_rsp   (smem_rsp),
		.lb_wr      (lb_wr),
		.busy       (busy)
	);

	line_store u_lines (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.lb_wr      (lb_wr),
		.line_num   (line_num),
		.pix        (pix)
	);

endmodule

`default_nettype wire

// File: test/tb_sprite_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_unit;

	localparam int SHOW_PIX   = 360;	// visible pixels per line
	localparam int NUM_LINES  = 10;
	localparam int RISE_LIMIT = 8;	// clocks allowed for busy to rise
	localparam int FALL_LIMIT = 6000;	// clocks allowed for the sequencer to finish

	logic clk;
	logic line_start;
	logic pre_vline;
	spu_pkg::host_wr_t host;
	spu_pkg::pix_t pix;
	logic busy;

	// testbench copies of the tables
	logic [7:0] desc_m [256];
	logic [7:0] pal_m [256];
	logic [15:0] smem_m [512];
	spu_pkg::pix_t exp_line [512];	// what the display bank should hold
	int pix_errs;
	int ctl_errs;
	logic timed_out;	// busy never rose or never fell

	sprite_unit DUT (
		.clk        (clk),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.host       (host),
		.pix        (pix),
		.busy       (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns
	end

	// nothing runs or shows while line_start is held
	assert property (@(posedge clk) line_start |-> (!busy && !pix.en))
	else
	begin
		ctl_errs++;
		$display("[FAIL] %0t busy or pix.en high while line_start is high", $time);
	end

	// ----------------------------------------------------------------------
	// scene setup and host loading
	// ----------------------------------------------------------------------
	task automatic set_sprite(input int n, input logic [1:0] cres, input logic [5:0] pal,
		input int xpos, input int xsz, input int ypos, input int ysz, input int adr);
		int base;
		base = n * 8;
		desc_m[base + 0] = 8'(xpos);
		desc_m[base + 1] = {xpos[8], 7'(xsz)};
		desc_m[base + 2] = 8'(ypos);
		desc_m[base + 3] = {ypos[8], 7'(ysz)};
		desc_m[base + 4] = {pal, cres};
		desc_m[base + 5] = 8'(adr);
		desc_m[base + 6] = {7'd0, adr[8]};
		desc_m[base + 7] = 8'h00;	// reserved
	endtask

	task automatic setup_scene();
		for (int i = 0; i < 256; i++)
			desc_m[i] = 8'h00;	// all sprites off
		for (int i = 0; i < 256; i++)
			pal_m[i] = 8'($urandom);	// bit 7 random so about half transparent
		for (int i = 0; i < 512; i++)
			smem_m[i] = 16'($urandom);
		//          n   cres   pal    xpos xsz ypos ysz adr
		set_sprite(0,  2'd1, 6'h05, 10,  2, 1,   3, 0);	// 4 colour
		set_sprite(1,  2'd2, 6'h2c, 40,  3, 0,   4, 32);	// 16 colour
		set_sprite(2,  2'd3, 6'h00, 100, 4, 2,   5, 64);	// true colour
		set_sprite(3,  2'd1, 6'h11, 14,  1, 2,   2, 96);	// on top of sprite 0
		set_sprite(4,  2'd0, 6'h3a, 200, 3, 0,   8, 128);	// off, must stay invisible
		set_sprite(7,  2'd2, 6'h3f, 300, 2, 3,   2, 300);	// xpos and adr bit 8
		set_sprite(10, 2'd1, 6'h0f, 60,  1, 258, 4, 440);	// ypos bit 8, never on screen
		set_sprite(20, 2'd3, 6'h00, 104, 2, 4,   1, 200);	// over sprite 2
		set_sprite(31, 2'd1, 6'h20, 350, 1, 5,   3, 400);	// last sprite
	endtask

	task automatic host_write(input spu_pkg::host_target_e tgt, input int addr,
		input logic [15:0] data);
		@(negedge clk);
		host.we     = 1'b1;
		host.target = tgt;
		host.addr   = 9'(addr);
		host.data   = data;
	endtask

	task automatic load_tables();
		for (int i = 0; i < 256; i++)
			host_write(spu_pkg::HT_SFILE, i, {~desc_m[i], desc_m[i]});	// upper byte ignored
		for (int i = 0; i < 256; i++)
			host_write(spu_pkg::HT_PAL, i, {8'h00, pal_m[i]});
		for (int i = 0; i < 512; i++)
			host_write(spu_pkg::HT_SMEM, i, smem_m[i]);
		@(negedge clk);
		host.we = 1'b0;
	endtask

	// ----------------------------------------------------------------------
	// reference model of one drawn line
	// ----------------------------------------------------------------------
	task automatic build_expected(input int line);
		int base;
		int xpos;
		int xsz;
		int ypos;
		int ysz;
		int adr;
		int row;
		int x;
		int width;
		logic [1:0] cres;
		logic [5:0] pal;
		logic [15:0] word;
		logic [7:0] field;
		logic [7:0] idx;
		logic [7:0] ent;
		for (int i = 0; i < 512; i++)
			exp_line[i] = '0;
		for (int n = 0; n < 32 && line >= 0; n++)	// later sprites overwrite earlier
		begin
			base = n * 8;
			cres = desc_m[base + 4][1:0];
			pal  = desc_m[base + 4][7:2];
			xpos = {desc_m[base + 1][7], desc_m[base + 0]};
			xsz  = desc_m[base + 1][6:0];
			ypos = {desc_m[base + 3][7], desc_m[base + 2]};
			ysz  = desc_m[base + 3][6:0];
			adr  = {desc_m[base + 6][0], desc_m[base + 5]};
			if (cres != spu_pkg::CRES_OFF && line >= ypos && line < ypos + ysz)
			begin
				row   = line - ypos;	// row r starts at adr plus r times xsz
				x     = xpos;
				width = (cres == spu_pkg::CRES_4C) ? 2 : (cres == spu_pkg::CRES_16C) ? 4 : 8;
				for (int w = 0; w < xsz; w++)
				begin
					word = smem_m[(adr + row * xsz + w) % 512];
					for (int p = 0; p < 16 / width; p++)
					begin
						// msb field first
						field = 8'((word >> (16 - width * (p + 1))) & ((1 << width) - 1));
						if (cres == spu_pkg::CRES_TC)
						begin
							if (!field[7])
								exp_line[x % 512] = {1'b1, field[5:0]};
						end
						else
						begin
							if (cres == spu_pkg::CRES_4C)
								idx = {pal, field[1:0]};
							else
								idx = {pal[5:2], field[3:0]};
							ent = pal_m[idx];
							if (!ent[7])	// transparent entry leaves the old pixel
								exp_line[x % 512] = {1'b1, ent[5:0]};
						end
						x++;
					end
				end
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// per-line checks
	// ----------------------------------------------------------------------
	// pixel k is held from edge 4k+2 to 4k+5
	task automatic capture_line(input int line);
		int edge_n;
		edge_n = 0;
		for (int k = 0; k < SHOW_PIX; k++)
		begin
			while (edge_n < 4 * k + 3)
			begin
				@(posedge clk);
				edge_n++;
			end
			@(negedge clk);	// mid slot
			assert (pix == exp_line[k])
			else
			begin
				pix_errs++;
				$display("[FAIL] %0t line %0d x %0d pix %h expected %h",
					$time, line, k, pix, exp_line[k]);
			end
		end
	endtask

	task automatic watch_busy(input int line);
		int cnt;
		cnt = 0;
		while (!busy && cnt < RISE_LIMIT)
		begin
			@(negedge clk);
			cnt++;
		end
		if (!busy)
		begin
			timed_out = 1'b1;
			$display("timeout waiting for busy to rise on line %0d", line);
		end
		else
		begin
			assert (cnt == 1)	// up on edge 1
			else
			begin
				ctl_errs++;
				$display("[FAIL] %0t line %0d busy rose after %0d clocks", $time, line, cnt);
			end
			cnt = 0;
			while (busy && cnt < FALL_LIMIT)
			begin
				@(negedge clk);
				cnt++;
			end
			if (busy)
			begin
				timed_out = 1'b1;
				$display("timeout waiting for busy to fall on line %0d", line);
			end
		end
	endtask

	// the display bank holds what was drawn on the line before
	task automatic run_line(input int line);
		build_expected(line - 1);
		fork
			capture_line(line);
			watch_busy(line);
		join
	endtask

	initial
	begin
		void'($urandom(3));
		pix_errs   = 0;
		ctl_errs   = 0;
		timed_out  = 1'b0;
		line_start = 1'b1;
		pre_vline  = 1'b1;	// first line is line 0
		host       = '0;
		repeat (16) @(negedge clk);
		assert (!pix.en && !busy)
		else
		begin
			ctl_errs++;
			$display("[FAIL] %0t pix.en or busy high after reset", $time);
		end
		setup_scene();
		load_tables();	// tables go in while line_start is high
		line_start = 1'b0;
		run_line(0);
		for (int l = 1; l < NUM_LINES && !timed_out; l++)
		begin
			@(negedge clk);
			line_start = 1'b1;	// one clock pulse
			pre_vline  = 1'b0;
			@(negedge clk);
			line_start = 1'b0;
			run_line(l);
		end
		$display("pixel errors %0d, control errors %0d", pix_errs, ctl_errs);
		if (!timed_out && pix_errs == 0 && ctl_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
src/spu_pkg.sv
src/sprite_regfile.sv
src/sprite_palette.sv
src/sprite_mem.sv
src/sprite_sequencer.sv
src/line_store.sv
src/sprite_unit.sv
test/tb_sprite_unit.sv
